/* source/srrc_coef_pkg.sv */
`default_nettype none

package srrc_coef_pkg;

    // Output sample format of the shaping filter
    localparam int sample_width = 18;
    localparam int samples_per_symbol = 4;
    localparam int tap_count = 17;

    typedef logic signed [sample_width-1:0] sample_t;

    // Root-raised-cosine taps, symmetric around the centre tap 8.
    // The taps are prescaled so that five summed terms never exceed the sample range
    localparam sample_t srrc_taps [tap_count] = '{
        314,
        -2115,
        -5743,
        -6936,
        -719,
        15367,
        37897,
        57966,
        66023,
        57966,
        37897,
        15367,
        -719,
        -6936,
        -5743,
        -2115,
        314
    };

endpackage

`default_nettype wire

/* source/tx_symbol_pkg.sv */
`default_nettype none

package tx_symbol_pkg;

    // A zero symbol fills the filter when the queue runs dry
    typedef enum logic [1:0] {
        sym_zero = 2'b00,
        sym_pos  = 2'b01,
        sym_neg  = 2'b10
    } symbol_t;

    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = 3;

    // Additive scrambler, polynomial x^7 + x^6 + 1
    localparam int scrambler_width = 7;
    localparam logic [scrambler_width-1:0] scrambler_seed = '1;

endpackage

`default_nettype wire

/* source/bit_scrambler_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_scrambler_mapper (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   bit_valid,
    input  wire logic                   bit_data,
    input  wire logic                   scramble_enable,
    output logic                        push,
    output tx_symbol_pkg::symbol_t      push_symbol
);

    import tx_symbol_pkg::*;

    logic [scrambler_width-1:0] scrambler;
    logic scrambler_out;
    logic coded_bit;

    // Feedback from the x^7 and x^6 stages, which is also the whitening bit
    assign scrambler_out = scrambler[scrambler_width-1] ^ scrambler[scrambler_width-2];
    assign coded_bit = bit_data ^ (scramble_enable & scrambler_out);

    // The scrambler steps on every input bit, also when scrambling is off,
    // so enabling it mid-stream stays aligned with the bit count
    always_ff @(posedge clk) begin
        if (reset) begin
            scrambler <= scrambler_seed;
            push <= 1'b0;
        end else begin
            push <= bit_valid;
            if (bit_valid) begin
                scrambler <= {scrambler[scrambler_width-2:0], scrambler_out};
            end
        end
    end

    // BPSK mapping: 0 goes to +1 and 1 goes to -1
    always_ff @(posedge clk) begin
        if (bit_valid) begin
            push_symbol <= coded_bit ? sym_neg : sym_pos;
        end
    end

endmodule

`default_nettype wire

/* source/symbol_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_fifo (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   push,
    input  tx_symbol_pkg::symbol_t      push_symbol,
    input  wire logic                   pop,
    output tx_symbol_pkg::symbol_t      head_symbol,
    output logic                        empty,
    output logic                        overflow
);

    import tx_symbol_pkg::*;

    symbol_t mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = (count == (fifo_addr_width + 1)'(fifo_depth));
    assign empty = (count == '0);

    // A full queue refuses the push even if a pop frees a slot in the same cycle
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;
    assign overflow = push & full;

    // Fallthrough read, the oldest entry is always on the output
    assign head_symbol = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_symbol;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/srrc_polyphase_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module srrc_polyphase_filter (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  tx_symbol_pkg::symbol_t      head_symbol,
    input  wire logic                   empty,
    output logic                        pop,
    output srrc_coef_pkg::sample_t      sample,
    output logic [1:0]                  sample_phase,
    output logic                        sample_valid,
    output logic                        underrun
);

    import srrc_coef_pkg::*;
    import tx_symbol_pkg::*;

    // Five symbols span the 17 taps at four samples per symbol
    symbol_t hist [(tap_count + samples_per_symbol - 1) / samples_per_symbol];
    symbol_t window [(tap_count + samples_per_symbol - 1) / samples_per_symbol];
    symbol_t new_symbol;
    logic [1:0] phase;
    logic symbol_start;
    sample_t sum;

    // Coefficient lookup with sign taken from the symbol, so no multiplier is needed
    function automatic sample_t tap_term(input symbol_t sym, input int unsigned idx);
        sample_t coef;
        coef = '0;
        if (idx < tap_count) begin
            coef = srrc_taps[idx];
        end
        case (sym)
            sym_pos: return coef;
            sym_neg: return -coef;
            default: return '0;
        endcase
    endfunction

    assign symbol_start = (phase == 2'd0);
    assign pop = symbol_start & ~empty;

    // An empty queue feeds a zero symbol instead of stalling the sample stream
    assign new_symbol = empty ? sym_zero : head_symbol;

    // The window is the history as seen in this cycle, with the new symbol
    // already in slot 0 at phase 0
    always_comb begin
        window[0] = symbol_start ? new_symbol : hist[0];
        for (int k = 1; k < $size(hist); k++) begin
            window[k] = symbol_start ? hist[k-1] : hist[k];
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < $size(window); k++) begin
            sum = sum + tap_term(window[k], samples_per_symbol * k + phase);
        end
    end

    // Outside phase 0 the window equals the history, so loading it every cycle is safe
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 2'd0;
            sample_valid <= 1'b0;
            underrun <= 1'b0;
            for (int k = 0; k < $size(hist); k++) begin
                hist[k] <= sym_zero;
            end
        end else begin
            phase <= phase + 1'b1;
            sample_valid <= 1'b1;
            underrun <= symbol_start & empty;
            for (int k = 0; k < $size(hist); k++) begin
                hist[k] <= window[k];
            end
        end
    end

    // Underrun is registered together with the phase 0 sample it belongs to
    always_ff @(posedge clk) begin
        sample <= sum;
        sample_phase <= phase;
    end

endmodule

`default_nettype wire

/* source/bpsk_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bpsk_tx_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   bit_valid,
    input  wire logic                   bit_data,
    input  wire logic                   scramble_enable,
    output srrc_coef_pkg::sample_t      sample,
    output logic [1:0]                  sample_phase,
    output logic                        sample_valid,
    output logic                        overflow,
    output logic                        underrun
);

    import tx_symbol_pkg::*;

    logic push;
    symbol_t push_symbol;
    logic pop;
    symbol_t head_symbol;
    logic empty;

    // Bits in, one symbol push per accepted bit
    bit_scrambler_mapper mapper_i (
        .clk             (clk),
        .reset           (reset),
        .bit_valid       (bit_valid),
        .bit_data        (bit_data),
        .scramble_enable (scramble_enable),
        .push            (push),
        .push_symbol     (push_symbol)
    );

    symbol_fifo fifo_i (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_symbol (push_symbol),
        .pop         (pop),
        .head_symbol (head_symbol),
        .empty       (empty),
        .overflow    (overflow)
    );

    // The filter sets the symbol rate and pulls from the queue once per four samples
    srrc_polyphase_filter filter_i (
        .clk          (clk),
        .reset        (reset),
        .head_symbol  (head_symbol),
        .empty        (empty),
        .pop          (pop),
        .sample       (sample),
        .sample_phase (sample_phase),
        .sample_valid (sample_valid),
        .underrun     (underrun)
    );

endmodule

`default_nettype wire

/* bench/tx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_checker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   bit_valid,
    input  wire logic                   bit_data,
    input  wire logic                   scramble_enable,
    input  wire srrc_coef_pkg::sample_t sample,
    input  wire logic [1:0]             sample_phase,
    input  wire logic                   sample_valid,
    input  wire logic                   overflow,
    input  wire logic                   underrun,
    output int                          error_count,
    output int                          sample_count,
    output int                          nonzero_count,
    output int                          overflow_count
);

    import srrc_coef_pkg::*;
    import tx_symbol_pkg::*;

    logic [scrambler_width-1:0] scr_state;
    // Bit 0 holds the newest symbol, bit 4 the oldest
    logic [4:0] pos_hist;
    logic [4:0] neg_hist;
    logic pending;
    int pending_sym;
    // Queue model, each entry stamped with the cycle of its push
    int sym_q[$];
    int stamp_q[$];
    int cycle;
    int phase;
    logic in_reset;

    task automatic flag_error(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        error_count++;
    endtask

    // Whitening bit of the x^7 + x^6 + 1 scrambler
    function automatic logic scrambler_bit(input logic [scrambler_width-1:0] state);
        return state[6] ^ state[5];
    endfunction

    // Expected sample, slot k uses tap 4k + p and taps past the end count as zero
    function automatic int sample_ref(input logic [4:0] pos, input logic [4:0] neg,
                                      input int p);
        int acc;
        int idx;
        acc = 0;
        for (int k = 0; k < 5; k++) begin
            idx = samples_per_symbol * k + p;
            if (idx < tap_count && pos[k]) begin
                acc = acc + int'(srrc_taps[idx]);
            end else if (idx < tap_count && neg[k]) begin
                acc = acc - int'(srrc_taps[idx]);
            end
        end
        return acc;
    endfunction

    initial begin
        error_count = 0;
        sample_count = 0;
        nonzero_count = 0;
        overflow_count = 0;
        in_reset = 1'b0;
    end

    always @(posedge clk) begin : compare
        int expected;
        logic coded;
        logic take;
        logic full;
        if (reset) begin
            if (in_reset && (sample_valid !== 1'b0 || overflow !== 1'b0
                             || underrun !== 1'b0)) begin
                flag_error("sample_valid, overflow or underrun high during reset");
            end
            in_reset = 1'b1;
            scr_state = scrambler_seed;
            pos_hist = '0;
            neg_hist = '0;
            pending = 1'b0;
            sym_q.delete();
            stamp_q.delete();
            cycle = 0;
            phase = 0;
        end else begin
            cycle++;
            if (sample_valid !== (cycle >= 2)) begin
                flag_error($sformatf("sample_valid expected %0b, got %b", cycle >= 2,
                                     sample_valid));
            end
            if (sample_valid === 1'b1) begin
                sample_count++;
                if (sample_phase !== 2'(phase)) begin
                    flag_error($sformatf("phase expected %0d, got %0d", phase, sample_phase));
                end
                if (phase == 0) begin
                    // The filter took its symbol in the previous cycle
                    take = (sym_q.size() > 0) && (stamp_q[0] < cycle - 1);
                    if (underrun !== !take) begin
                        flag_error($sformatf("underrun expected %0b, got %b", !take, underrun));
                    end
                    pos_hist = {pos_hist[3:0], 1'b0};
                    neg_hist = {neg_hist[3:0], 1'b0};
                    if (take) begin
                        pos_hist[0] = (sym_q[0] > 0);
                        neg_hist[0] = (sym_q[0] < 0);
                        void'(sym_q.pop_front());
                        void'(stamp_q.pop_front());
                    end
                end else if (underrun !== 1'b0) begin
                    flag_error($sformatf("underrun high at phase %0d", phase));
                end
                expected = sample_ref(pos_hist, neg_hist, phase);
                if ($isunknown(sample) || int'(sample) != expected) begin
                    flag_error($sformatf("sample at phase %0d expected %0d, got %0d",
                                         phase, expected, int'(sample)));
                end
                if (sample != 0) begin
                    nonzero_count++;
                end
                phase = (phase + 1) % samples_per_symbol;
            end
            // The push of a bit is in flight one cycle after its strobe
            // With the pop above applied, the model queue matches the DUT queue of this cycle
            full = (sym_q.size() == fifo_depth);
            if (overflow !== (pending & full)) begin
                flag_error($sformatf("overflow expected %0b, got %b", pending & full, overflow));
            end
            if (overflow === 1'b1) begin
                overflow_count++;
            end else if (pending) begin
                sym_q.push_back(pending_sym);
                stamp_q.push_back(cycle);
            end
            pending = bit_valid;
            if (bit_valid) begin
                coded = bit_data ^ (scramble_enable & scrambler_bit(scr_state));
                pending_sym = coded ? -1 : 1;
                scr_state = {scr_state[5:0], scrambler_bit(scr_state)};
            end
        end
    end

endmodule

`default_nettype wire

/* bench/bpsk_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpsk_tx_tb;

    import srrc_coef_pkg::*;

    logic clk;
    logic reset;
    logic bit_valid;
    logic bit_data;
    logic scramble_enable;
    sample_t sample;
    logic [1:0] sample_phase;
    logic sample_valid;
    logic overflow;
    logic underrun;
    int error_count;
    int sample_count;
    int nonzero_count;
    int overflow_count;
    int bench_errors;
    int timeouts;
    int last_overflows;
    int seed;

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    bpsk_tx_top bpsk_tx_top_i (
        .clk             (clk),
        .reset           (reset),
        .bit_valid       (bit_valid),
        .bit_data        (bit_data),
        .scramble_enable (scramble_enable),
        .sample          (sample),
        .sample_phase    (sample_phase),
        .sample_valid    (sample_valid),
        .overflow        (overflow),
        .underrun        (underrun)
    );

    tx_checker tx_checker_i (
        .clk             (clk),
        .reset           (reset),
        .bit_valid       (bit_valid),
        .bit_data        (bit_data),
        .scramble_enable (scramble_enable),
        .sample          (sample),
        .sample_phase    (sample_phase),
        .sample_valid    (sample_valid),
        .overflow        (overflow),
        .underrun        (underrun),
        .error_count     (error_count),
        .sample_count    (sample_count),
        .nonzero_count   (nonzero_count),
        .overflow_count  (overflow_count)
    );

    task automatic finish_run();
        @(negedge clk);
        $display("Checked %0d samples: %0d value errors, %0d bench errors, %0d timeouts",
                 sample_count, error_count, bench_errors, timeouts);
        if (error_count == 0 && bench_errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic send_bit(input logic value);
        bit_valid <= 1'b1;
        bit_data <= value;
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        bit_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // Random bits at the symbol rate, one bit every four clocks
    task automatic send_stream(input int count);
        int r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            send_bit(r[0]);
            idle(samples_per_symbol - 1);
        end
    endtask

    // An underrun means the queue has run dry
    task automatic wait_for_underrun(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (underrun !== 1'b1 && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (underrun !== 1'b1) begin
            $display("Timeout: the queue never drained after the %s", what);
            timeouts++;
            finish_run();
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic wait_for_nonzero(input int target, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (nonzero_count < target && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (nonzero_count < target) begin
            $display("Timeout: only %0d of %0d impulse samples came out", nonzero_count, target);
            timeouts++;
            finish_run();
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic check_overflows(input string what, input logic want_some);
        @(negedge clk);
        if ((overflow_count > last_overflows) != want_some) begin
            $display("ERR @%0t: %s gave %0d overflows, expected %s", $time, what,
                     overflow_count - last_overflows, want_some ? "some" : "none");
            bench_errors++;
        end
        last_overflows = overflow_count;
        @(posedge clk);
    endtask

    initial begin
        int r;
        seed = 6424;
        reset = 1'b1;
        bit_valid = 1'b0;
        bit_data = 1'b0;
        scramble_enable = 1'b0;
        bench_errors = 0;
        timeouts = 0;
        last_overflows = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        idle(12);

        // A single unscrambled 0 gives the whole pulse shape
        send_bit(1'b0);
        idle(1);
        wait_for_nonzero(tap_count, 80);
        wait_for_underrun(40, "impulse");
        @(negedge clk);
        if (nonzero_count != tap_count) begin
            $display("ERR @%0t: impulse gave %0d non-zero samples, expected %0d", $time,
                     nonzero_count, tap_count);
            bench_errors++;
        end
        @(posedge clk);

        send_stream(40);
        wait_for_underrun(60, "unscrambled stream");
        check_overflows("unscrambled stream", 1'b0);

        scramble_enable <= 1'b1;
        send_stream(40);
        wait_for_underrun(60, "scrambled stream");
        check_overflows("scrambled stream", 1'b0);

        // Back-to-back bits overrun the eight-entry queue
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            send_bit(r[0]);
        end
        idle(1);
        wait_for_underrun(200, "burst");
        check_overflows("burst", 1'b1);

        send_stream(16);
        wait_for_underrun(60, "recovery stream");
        check_overflows("recovery stream", 1'b0);
        idle(24);
        finish_run();
    end

endmodule

`default_nettype wire

/* compile.f */
source/srrc_coef_pkg.sv
source/tx_symbol_pkg.sv
source/bit_scrambler_mapper.sv
source/symbol_fifo.sv
source/srrc_polyphase_filter.sv
source/bpsk_tx_top.sv
bench/tx_checker.sv
bench/bpsk_tx_tb.sv

/* Bender.yml */
package:
  name: bpsk_tx

sources:
  - files:
      - source/srrc_coef_pkg.sv
      - source/tx_symbol_pkg.sv
      - source/bit_scrambler_mapper.sv
      - source/symbol_fifo.sv
      - source/srrc_polyphase_filter.sv
      - source/bpsk_tx_top.sv
  - target: test
    files:
      - bench/tx_checker.sv
      - bench/bpsk_tx_tb.sv
